// ==== id_pkg.sv ====
/*
  Shared definitions for the RV32I instruction decode stage.
  Holds widths, major opcodes, selector encodings and the packed structs
  that travel between decoder, operand mux, control FSM and stage ports.
*/
package id_pkg;

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;
  // Byte step to the second word of a misaligned access
  localparam int unsigned word_incr  = 4;

  // Major opcodes of the supported instruction classes
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011
  } opcode_e;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
    alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
  } alu_op_e;

  typedef enum logic [1:0] {
    op_a_reg,
    op_a_fwd,
    op_a_pc,
    op_a_zero
  } op_a_sel_e;

  typedef enum logic {
    op_b_reg,
    op_b_imm
  } op_b_sel_e;

  typedef enum logic [2:0] {
    imm_b_i, imm_b_s, imm_b_b, imm_b_u, imm_b_j,
    imm_b_incr_pc,
    imm_b_incr_addr
  } imm_b_sel_e;

  typedef enum logic {
    wb_ex,
    wb_lsu
  } wb_sel_e;

  // Decoder output. data_size is funct3[1:0]: byte, half, word
  typedef struct packed {
    alu_op_e                alu_op;
    op_a_sel_e              op_a_sel;
    op_b_sel_e              op_b_sel;
    imm_b_sel_e             imm_b_sel;
    wb_sel_e                wb_sel;
    logic                   rf_we;
    logic [reg_addr_w-1:0]  rs1;
    logic [reg_addr_w-1:0]  rs2;
    logic [reg_addr_w-1:0]  rd;
    logic                   data_req;
    logic                   data_we;
    logic [1:0]             data_size;
    logic                   data_sign_ext;
    logic                   branch;
    logic                   jump;
  } dec_ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] i;
    logic [xlen-1:0] s;
    logic [xlen-1:0] b;
    logic [xlen-1:0] u;
    logic [xlen-1:0] j;
  } imm_t;

  typedef struct packed {
    alu_op_e         alu_op;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
  } ex_req_t;

  typedef struct packed {
    logic            req;
    logic            we;
    logic [1:0]      size;
    logic            sign_ext;
    logic [xlen-1:0] wdata;
  } lsu_req_t;

endpackage

// ==== id_decoder.sv ====
/*
  Combinational RV32I decoder for the ID stage.
  Turns the instruction word into the control struct and the five
  sign-extended immediates, and flags unsupported encodings as illegal.
*/
`timescale 1ns/100ps

module id_decoder #(
  parameter bit rv32e = 1'b0
) (
  input  logic [id_pkg::xlen-1:0] instr_rdata_i,
  output id_pkg::dec_ctrl_t       ctrl_o,
  output id_pkg::imm_t            imm_o,
  output logic                    illegal_insn_o
);
  import id_pkg::*;

  opcode_e    opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       use_rs1;
  logic       use_rs2;
  logic       illegal_op;
  logic       illegal_reg;

  // funct3 to ALU op for OP and OP-IMM, alt picks sub or sra
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = alt ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  assign funct7 = instr_rdata_i[31:25];
  assign funct3 = instr_rdata_i[14:12];

  ////////////////////////////////////////////////////////////////////////////
  // Immediates
  assign imm_o.i = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_o.s = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_o.b = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                    instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_o.u = {instr_rdata_i[31:12], 12'b0};
  assign imm_o.j = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                    instr_rdata_i[30:21], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  always_comb begin
    ctrl_o           = '0;
    ctrl_o.alu_op    = alu_add;
    ctrl_o.op_a_sel  = op_a_reg;
    ctrl_o.op_b_sel  = op_b_reg;
    ctrl_o.imm_b_sel = imm_b_i;
    ctrl_o.wb_sel    = wb_ex;
    ctrl_o.rs1       = instr_rdata_i[19:15];
    ctrl_o.rs2       = instr_rdata_i[24:20];
    ctrl_o.rd        = instr_rdata_i[11:7];
    use_rs1          = 1'b0;
    use_rs2          = 1'b0;
    illegal_op       = 1'b0;

    case (opcode)
      opc_op: begin
        ctrl_o.alu_op = arith_op(funct3, funct7[5]);
        ctrl_o.rf_we  = 1'b1;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        illegal_op    = (funct7 != 7'b0) &&
                        !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      opc_op_imm: begin
        ctrl_o.alu_op   = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
        ctrl_o.op_b_sel = op_b_imm;
        ctrl_o.rf_we    = 1'b1;
        use_rs1         = 1'b1;
        // Shift amounts only fit in five bits
        illegal_op      = (funct3 == 3'b001 && funct7 != 7'b0) ||
                          (funct3 == 3'b101 && funct7 != 7'b0 && funct7 != 7'b0100000);
      end
      opc_lui, opc_auipc: begin
        ctrl_o.op_a_sel  = (opcode == opc_lui) ? op_a_zero : op_a_pc;
        ctrl_o.op_b_sel  = op_b_imm;
        ctrl_o.imm_b_sel = imm_b_u;
        ctrl_o.rf_we     = 1'b1;
      end
      opc_jal, opc_jalr: begin
        // ALU forms the link value, the target is formed outside this stage
        ctrl_o.jump      = 1'b1;
        ctrl_o.op_a_sel  = op_a_pc;
        ctrl_o.op_b_sel  = op_b_imm;
        ctrl_o.imm_b_sel = imm_b_incr_pc;
        ctrl_o.rf_we     = 1'b1;
        use_rs1          = (opcode == opc_jalr);
        illegal_op       = (opcode == opc_jalr) && (funct3 != 3'b000);
      end
      opc_branch: begin
        ctrl_o.branch    = 1'b1;
        ctrl_o.imm_b_sel = imm_b_b;
        use_rs1          = 1'b1;
        use_rs2          = 1'b1;
        case (funct3)
          3'b000:  ctrl_o.alu_op = alu_eq;
          3'b001:  ctrl_o.alu_op = alu_ne;
          3'b100:  ctrl_o.alu_op = alu_lt;
          3'b101:  ctrl_o.alu_op = alu_ge;
          3'b110:  ctrl_o.alu_op = alu_ltu;
          3'b111:  ctrl_o.alu_op = alu_geu;
          default: illegal_op    = 1'b1;
        endcase
      end
      opc_load: begin
        ctrl_o.data_req      = 1'b1;
        ctrl_o.data_size     = funct3[1:0];
        ctrl_o.data_sign_ext = ~funct3[2];
        ctrl_o.op_b_sel      = op_b_imm;
        ctrl_o.wb_sel        = wb_lsu;
        ctrl_o.rf_we         = 1'b1;
        use_rs1              = 1'b1;
        illegal_op           = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      opc_store: begin
        ctrl_o.data_req  = 1'b1;
        ctrl_o.data_we   = 1'b1;
        ctrl_o.data_size = funct3[1:0];
        ctrl_o.op_b_sel  = op_b_imm;
        ctrl_o.imm_b_sel = imm_b_s;
        use_rs1          = 1'b1;
        use_rs2          = 1'b1;
        illegal_op       = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: illegal_op = 1'b1;
    endcase

    // RV32E has only x0..x15
    illegal_reg = rv32e && ((use_rs1 && ctrl_o.rs1[4]) || (use_rs2 && ctrl_o.rs2[4]) ||
                            (ctrl_o.rf_we && ctrl_o.rd[4]));

    // Illegal instructions retire as single-cycle with no side effects
    if (illegal_op || illegal_reg) begin
      ctrl_o.rf_we    = 1'b0;
      ctrl_o.data_req = 1'b0;
      ctrl_o.branch   = 1'b0;
      ctrl_o.jump     = 1'b0;
    end
  end

  assign illegal_insn_o = illegal_op | illegal_reg;

  a_multicycle_kind_onehot: assert final ($onehot0({ctrl_o.data_req, ctrl_o.branch,
                                                    ctrl_o.jump}));

endmodule

// ==== id_operand_mux.sv ====
/*
  ALU operand builder for the ID stage.
  Picks operand A and B from registers, PC and immediates, and takes
  over both operands while the LSU asks for a second access address.
*/
`timescale 1ns/100ps

module id_operand_mux (
  input  id_pkg::dec_ctrl_t       ctrl_i,
  input  id_pkg::imm_t            imm_i,
  input  logic [id_pkg::xlen-1:0] rs1_data_i,
  input  logic [id_pkg::xlen-1:0] rs2_data_i,
  input  logic [id_pkg::xlen-1:0] pc_i,
  input  logic [id_pkg::xlen-1:0] lsu_addr_last_i,
  input  logic                    lsu_addr_incr_req_i,
  output id_pkg::ex_req_t         ex_req_o,
  output logic [id_pkg::xlen-1:0] store_wdata_o
);
  import id_pkg::*;

  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  imm_b_sel_e      imm_b_sel;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] op_a;

  // Misaligned access, second address is last address plus one word
  assign op_a_sel  = lsu_addr_incr_req_i ? op_a_fwd        : ctrl_i.op_a_sel;
  assign op_b_sel  = lsu_addr_incr_req_i ? op_b_imm        : ctrl_i.op_b_sel;
  assign imm_b_sel = lsu_addr_incr_req_i ? imm_b_incr_addr : ctrl_i.imm_b_sel;

  always_comb begin
    case (imm_b_sel)
      imm_b_i:         imm_b = imm_i.i;
      imm_b_s:         imm_b = imm_i.s;
      imm_b_b:         imm_b = imm_i.b;
      imm_b_u:         imm_b = imm_i.u;
      imm_b_j:         imm_b = imm_i.j;
      // No compressed instructions, so the PC step is a full word too
      imm_b_incr_pc:   imm_b = xlen'(word_incr);
      imm_b_incr_addr: imm_b = xlen'(word_incr);
      default:         imm_b = '0;
    endcase
  end

  always_comb begin
    case (op_a_sel)
      op_a_reg: op_a = rs1_data_i;
      op_a_fwd: op_a = lsu_addr_last_i;
      op_a_pc:  op_a = pc_i;
      default:  op_a = '0;
    endcase
  end

  assign ex_req_o.alu_op = ctrl_i.alu_op;
  assign ex_req_o.op_a   = op_a;
  assign ex_req_o.op_b   = (op_b_sel == op_b_imm) ? imm_b : rs2_data_i;

  // Store data comes straight from rs2, the LSU aligns it
  assign store_wdata_o   = rs2_data_i;

endmodule

// ==== id_register_file.sv ====
/*
  Flip-flop register file, two asynchronous read ports and one write port.
  Holds 16 registers for RV32E or 32 otherwise, x0 always reads zero.
*/
`timescale 1ns/100ps

module id_register_file #(
  parameter bit rv32e = 1'b0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [id_pkg::reg_addr_w-1:0] raddr_a_i,
  input  logic [id_pkg::reg_addr_w-1:0] raddr_b_i,
  input  logic [id_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [id_pkg::xlen-1:0]       wdata_i,
  input  logic                          we_i,
  output logic [id_pkg::xlen-1:0]       rdata_a_o,
  output logic [id_pkg::xlen-1:0]       rdata_b_o
);
  import id_pkg::*;

  localparam int unsigned num_regs = rv32e ? 16 : 32;
  localparam int unsigned idx_w    = rv32e ? 4 : 5;

  logic [xlen-1:0] regs_q [num_regs];

  // x0 has no storage
  assign regs_q[0] = '0;

  for (genvar g = 1; g < num_regs; g++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        regs_q[g] <= '0;
      end else if (we_i && (waddr_i == reg_addr_w'(g))) begin
        regs_q[g] <= wdata_i;
      end
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i[idx_w-1:0]];
  assign rdata_b_o = regs_q[raddr_b_i[idx_w-1:0]];

  // Decoder must have rejected out-of-range rd before the write
  a_waddr_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    we_i |-> (waddr_i < num_regs)
  );

endmodule

// ==== id_wb_ctrl.sv ====
/*
  ID/WB control FSM of the decode stage.
  Classifies each new instruction, stalls multicycle ones until EX or LSU
  signals completion, then grants the register write and pulses retirement.
  A taken branch or jump raises pc_set_o one cycle after it is new.
*/
`timescale 1ns/100ps

module id_wb_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_new_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  logic              illegal_i,
  input  logic              branch_decision_i,
  input  logic              ex_valid_i,
  input  logic              lsu_valid_i,
  output logic              rf_we_o,
  output logic              instr_executing_o,
  output logic              stall_o,
  output logic              pc_set_o,
  output logic              instr_ret_o
);

  typedef enum logic {
    st_idle,
    st_wait_multicycle
  } id_fsm_e;

  id_fsm_e state_q;
  id_fsm_e state_d;
  logic    multicycle_done_q;
  logic    multicycle_done_d;
  logic    branch_set_q;
  logic    branch_set_d;
  logic    multicycle_new;
  logic    completed;

  // Memory accesses, jumps and taken branches need a completion pulse
  assign multicycle_new = ctrl_i.data_req | ctrl_i.jump | (ctrl_i.branch & branch_decision_i);
  assign completed      = ctrl_i.data_req ? lsu_valid_i : ex_valid_i;

  // Still working on the current instruction
  assign instr_executing_o = instr_new_i | ~multicycle_done_q;
  assign pc_set_o          = branch_set_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q           <= st_idle;
      multicycle_done_q <= 1'b1;
      branch_set_q      <= 1'b0;
    end else begin
      state_q           <= state_d;
      multicycle_done_q <= multicycle_done_d;
      branch_set_q      <= branch_set_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  always_comb begin
    state_d           = state_q;
    multicycle_done_d = multicycle_done_q;
    branch_set_d      = 1'b0;
    rf_we_o           = 1'b0;
    stall_o           = 1'b0;
    instr_ret_o       = 1'b0;

    case (state_q)
      st_idle: begin
        // Classify only in the first cycle of an instruction
        if (instr_new_i) begin
          if (multicycle_new) begin
            state_d           = st_wait_multicycle;
            multicycle_done_d = 1'b0;
            branch_set_d      = ctrl_i.branch | ctrl_i.jump;
            stall_o           = 1'b1;
          end else begin
            multicycle_done_d = 1'b1;
            rf_we_o           = ctrl_i.rf_we & ~illegal_i;
            instr_ret_o       = 1'b1;
          end
        end
      end
      st_wait_multicycle: begin
        if (completed) begin
          state_d           = st_idle;
          multicycle_done_d = 1'b1;
          rf_we_o           = ctrl_i.rf_we & ~illegal_i;
          instr_ret_o       = 1'b1;
        end else begin
          stall_o = 1'b1;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  // EX and LSU never finish the one pending instruction together
  a_single_completion: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == st_wait_multicycle) |-> !(ex_valid_i && lsu_valid_i)
  );

endmodule

// ==== id_stage.sv ====
/*
  Instruction decode stage of a small in-order RV32I core.
  Connects decoder, operand mux, register file and ID/WB control, selects
  write-back data and issues the EX and LSU requests.
*/
`timescale 1ns/100ps

module id_stage #(
  parameter bit rv32e = 1'b0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // IF/ID register
  input  logic                    instr_valid_i,
  input  logic                    instr_new_i,
  input  logic [id_pkg::xlen-1:0] instr_rdata_i,
  input  logic [id_pkg::xlen-1:0] pc_i,
  // EX and LSU
  input  logic                    branch_decision_i,
  input  logic                    ex_valid_i,
  input  logic                    lsu_valid_i,
  input  logic                    lsu_addr_incr_req_i,
  input  logic [id_pkg::xlen-1:0] lsu_addr_last_i,
  input  logic [id_pkg::xlen-1:0] wdata_ex_i,
  input  logic [id_pkg::xlen-1:0] wdata_lsu_i,
  output id_pkg::ex_req_t         ex_req_o,
  output id_pkg::lsu_req_t        lsu_req_o,
  // Status and control
  output logic                    illegal_insn_o,
  output logic                    stall_o,
  output logic                    id_ready_o,
  output logic                    pc_set_o,
  output logic                    instr_ret_o
);
  import id_pkg::*;

  dec_ctrl_t       dec_ctrl;
  imm_t            dec_imm;
  logic            illegal_dec;
  logic            instr_new;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] store_wdata;
  logic [xlen-1:0] rf_wdata;
  logic            rf_we;
  logic            instr_executing;

  // Only a valid IF/ID entry starts an instruction
  assign instr_new      = instr_new_i & instr_valid_i;
  assign illegal_insn_o = illegal_dec & instr_valid_i;
  assign id_ready_o     = ~stall_o;

  id_decoder #(
    .rv32e (rv32e)
  ) i_id_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .ctrl_o         (dec_ctrl),
    .imm_o          (dec_imm),
    .illegal_insn_o (illegal_dec)
  );

  id_operand_mux i_id_operand_mux (
    .ctrl_i              (dec_ctrl),
    .imm_i               (dec_imm),
    .rs1_data_i          (rs1_data),
    .rs2_data_i          (rs2_data),
    .pc_i                (pc_i),
    .lsu_addr_last_i     (lsu_addr_last_i),
    .lsu_addr_incr_req_i (lsu_addr_incr_req_i),
    .ex_req_o            (ex_req_o),
    .store_wdata_o       (store_wdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Register file and write-back
  assign rf_wdata = (dec_ctrl.wb_sel == wb_lsu) ? wdata_lsu_i : wdata_ex_i;

  id_register_file #(
    .rv32e (rv32e)
  ) i_id_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec_ctrl.rs1),
    .raddr_b_i (dec_ctrl.rs2),
    .waddr_i   (dec_ctrl.rd),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  id_wb_ctrl i_id_wb_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_new_i       (instr_new),
    .ctrl_i            (dec_ctrl),
    .illegal_i         (illegal_insn_o),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .rf_we_o           (rf_we),
    .instr_executing_o (instr_executing),
    .stall_o           (stall_o),
    .pc_set_o          (pc_set_o),
    .instr_ret_o       (instr_ret_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // LSU request, held from the new cycle up to completion
  assign lsu_req_o.req      = dec_ctrl.data_req & instr_executing;
  assign lsu_req_o.we       = dec_ctrl.data_we;
  assign lsu_req_o.size     = dec_ctrl.data_size;
  assign lsu_req_o.sign_ext = dec_ctrl.data_sign_ext;
  assign lsu_req_o.wdata    = store_wdata;

endmodule

// ==== tb_id_stage.sv ====
/*
  Testbench for the RV32I instruction decode stage.
  Acts as the IF, EX and LSU stages around the DUT, keeps a model of the
  register file and checks operands, requests, stalls and retirement.
*/
`timescale 1ns/100ps

module tb_id_stage;
  import id_pkg::*;

  logic            clk_i;
  logic            rst_ni;
  logic            instr_valid_i;
  logic            instr_new_i;
  logic [xlen-1:0] instr_rdata_i;
  logic [xlen-1:0] pc_i;
  logic            branch_decision_i;
  logic            ex_valid_i;
  logic            lsu_valid_i;
  logic            lsu_addr_incr_req_i;
  logic [xlen-1:0] lsu_addr_last_i;
  logic [xlen-1:0] wdata_ex_i;
  logic [xlen-1:0] wdata_lsu_i;
  ex_req_t         ex_req_o;
  lsu_req_t        lsu_req_o;
  logic            illegal_insn_o;
  logic            stall_o;
  logic            id_ready_o;
  logic            pc_set_o;
  logic            instr_ret_o;

  // Expected architectural register values
  logic [xlen-1:0] reg_model [32];
  int unsigned     errors;
  int unsigned     checks;

  id_stage #(
    .rv32e (1'b0)
  ) i_id_stage (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .instr_new_i         (instr_new_i),
    .instr_rdata_i       (instr_rdata_i),
    .pc_i                (pc_i),
    .branch_decision_i   (branch_decision_i),
    .ex_valid_i          (ex_valid_i),
    .lsu_valid_i         (lsu_valid_i),
    .lsu_addr_incr_req_i (lsu_addr_incr_req_i),
    .lsu_addr_last_i     (lsu_addr_last_i),
    .wdata_ex_i          (wdata_ex_i),
    .wdata_lsu_i         (wdata_lsu_i),
    .ex_req_o            (ex_req_o),
    .lsu_req_o           (lsu_req_o),
    .illegal_insn_o      (illegal_insn_o),
    .stall_o             (stall_o),
    .id_ready_o          (id_ready_o),
    .pc_set_o            (pc_set_o),
    .instr_ret_o         (instr_ret_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoding
  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] enc_itype(input logic [6:0] opcode, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  // SW rs2, imm(rs1)
  function automatic logic [31:0] enc_sw(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking and stage handshakes
  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  // New instruction from IF, sampled at the following falling edge
  task automatic start_instr(input logic [31:0] instr, input logic [31:0] ex_data,
                             input logic taken);
    @(posedge clk_i);
    instr_valid_i     <= 1'b1;
    instr_new_i       <= 1'b1;
    instr_rdata_i     <= instr;
    wdata_ex_i        <= ex_data;
    branch_decision_i <= taken;
    pc_i              <= pc_i + 32'd4;
    @(negedge clk_i);
  endtask

  // IF keeps the word but it is no longer new
  task automatic hold_instr();
    @(posedge clk_i);
    instr_new_i       <= 1'b0;
    branch_decision_i <= 1'b0;
    @(negedge clk_i);
  endtask

  // EX or LSU answers after a random latency
  task automatic finish_multicycle(input logic from_lsu, input logic [31:0] data);
    int unsigned delay;
    delay = $urandom_range(4, 0);
    repeat (delay) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_val("stall_o", 32'(stall_o), 32'd1);
      check_val("lsu_req_o.req", 32'(lsu_req_o.req), 32'(from_lsu));
    end
    @(posedge clk_i);
    lsu_valid_i <= from_lsu;
    ex_valid_i  <= ~from_lsu;
    wdata_lsu_i <= data;
    @(negedge clk_i);
    // Retires in the completion cycle itself
    check_val("instr_ret_o", 32'(instr_ret_o), 32'd1);
    check_val("stall_o", 32'(stall_o), 32'd0);
    @(posedge clk_i);
    lsu_valid_i <= 1'b0;
    ex_valid_i  <= 1'b0;
  endtask

  task automatic run_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    logic [31:0] data;
    data = $urandom();
    start_instr(enc_itype(7'b0010011, 3'b000, rd, rs1, imm), data, 1'b0);
    check_val("ex_req_o.alu_op", 32'(ex_req_o.alu_op), 32'(alu_add));
    check_val("ex_req_o.op_a", ex_req_o.op_a, reg_model[rs1]);
    check_val("ex_req_o.op_b", ex_req_o.op_b, sext12(imm));
    check_val("illegal_insn_o", 32'(illegal_insn_o), 32'd0);
    check_val("instr_ret_o", 32'(instr_ret_o), 32'd1);
    check_val("stall_o", 32'(stall_o), 32'd0);
    // Written on the next rising edge, x0 stays zero
    if (rd != 5'd0) begin
      reg_model[rd] = data;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  initial begin
    logic [31:0] data;
    logic [11:0] imm;
    void'($urandom(7));
    errors              = 0;
    checks              = 0;
    rst_ni              = 1'b0;
    instr_valid_i       = 1'b0;
    instr_new_i         = 1'b0;
    instr_rdata_i       = '0;
    pc_i                = '0;
    branch_decision_i   = 1'b0;
    ex_valid_i          = 1'b0;
    lsu_valid_i         = 1'b0;
    lsu_addr_incr_req_i = 1'b0;
    lsu_addr_last_i     = '0;
    wdata_ex_i          = '0;
    wdata_lsu_i         = '0;
    foreach (reg_model[r]) begin
      reg_model[r] = '0;
    end

    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_val("stall_o", 32'(stall_o), 32'd0);
    check_val("pc_set_o", 32'(pc_set_o), 32'd0);
    check_val("instr_ret_o", 32'(instr_ret_o), 32'd0);
    check_val("lsu_req_o.req", 32'(lsu_req_o.req), 32'd0);

    // Fill x1..x8 from x0, then read each back
    for (int r = 1; r < 9; r++) begin
      run_addi(5'(r), 5'd0, 12'($urandom()));
    end
    for (int r = 1; r < 9; r++) begin
      run_addi(5'd0, 5'(r), 12'($urandom()));
    end

    // LW x10 with a second access address in between
    imm = 12'($urandom());
    start_instr(enc_itype(7'b0000011, 3'b010, 5'd10, 5'd2, imm), '0, 1'b0);
    check_val("ex_req_o.op_a", ex_req_o.op_a, reg_model[2]);
    check_val("ex_req_o.op_b", ex_req_o.op_b, sext12(imm));
    check_val("lsu_req_o.req", 32'(lsu_req_o.req), 32'd1);
    check_val("lsu_req_o.we", 32'(lsu_req_o.we), 32'd0);
    check_val("lsu_req_o.size", 32'(lsu_req_o.size), 32'd2);
    check_val("lsu_req_o.sign_ext", 32'(lsu_req_o.sign_ext), 32'd1);
    check_val("stall_o", 32'(stall_o), 32'd1);
    check_val("instr_ret_o", 32'(instr_ret_o), 32'd0);
    hold_instr();
    @(posedge clk_i);
    lsu_addr_incr_req_i <= 1'b1;
    lsu_addr_last_i     <= $urandom();
    @(negedge clk_i);
    check_val("ex_req_o.op_a", ex_req_o.op_a, lsu_addr_last_i);
    check_val("ex_req_o.op_b", ex_req_o.op_b, 32'd4);
    @(posedge clk_i);
    lsu_addr_incr_req_i <= 1'b0;
    data = $urandom();
    finish_multicycle(1'b1, data);
    reg_model[10] = data;
    run_addi(5'd0, 5'd10, 12'd0);

    // SW x4 to an x5 based address
    imm = 12'($urandom());
    start_instr(enc_sw(5'd5, 5'd4, imm), '0, 1'b0);
    check_val("ex_req_o.op_a", ex_req_o.op_a, reg_model[5]);
    check_val("ex_req_o.op_b", ex_req_o.op_b, sext12(imm));
    check_val("lsu_req_o.wdata", lsu_req_o.wdata, reg_model[4]);
    check_val("lsu_req_o.we", 32'(lsu_req_o.we), 32'd1);
    check_val("lsu_req_o.size", 32'(lsu_req_o.size), 32'd2);
    check_val("lsu_req_o.req", 32'(lsu_req_o.req), 32'd1);
    hold_instr();
    finish_multicycle(1'b1, $urandom());

    // Taken branch
    start_instr(enc_beq(5'd1, 5'd3, 13'h010), '0, 1'b1);
    check_val("ex_req_o.alu_op", 32'(ex_req_o.alu_op), 32'(alu_eq));
    check_val("ex_req_o.op_a", ex_req_o.op_a, reg_model[1]);
    check_val("ex_req_o.op_b", ex_req_o.op_b, reg_model[3]);
    check_val("stall_o", 32'(stall_o), 32'd1);
    check_val("pc_set_o", 32'(pc_set_o), 32'd0);
    hold_instr();
    check_val("pc_set_o", 32'(pc_set_o), 32'd1);
    finish_multicycle(1'b0, '0);

    // Not-taken branch retires at once
    start_instr(enc_beq(5'd1, 5'd2, 13'h020), '0, 1'b0);
    check_val("instr_ret_o", 32'(instr_ret_o), 32'd1);
    check_val("stall_o", 32'(stall_o), 32'd0);
    hold_instr();
    check_val("pc_set_o", 32'(pc_set_o), 32'd0);

    // Unknown opcode aimed at x6
    start_instr(enc_itype(7'b1111111, 3'b000, 5'd6, 5'd1, 12'h0), $urandom(), 1'b0);
    check_val("illegal_insn_o", 32'(illegal_insn_o), 32'd1);
    check_val("instr_ret_o", 32'(instr_ret_o), 32'd1);
    check_val("stall_o", 32'(stall_o), 32'd0);
    run_addi(5'd0, 5'd6, 12'd0);

    @(posedge clk_i);
    instr_new_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reset and stall rules
  a_reset_quiet: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> !stall_o && !pc_set_o && !instr_ret_o && !lsu_req_o.req
  ) else begin
    errors++;
    $display("Assertion failed at %0t ns: outputs active right after reset", $time);
  end

  a_ready_inverse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) id_ready_o == !stall_o
  ) else begin
    errors++;
    $display("Assertion failed at %0t ns: id_ready_o is not the inverse of stall_o", $time);
  end

  a_no_retire_in_stall: assert property (
    @(posedge clk_i) disable iff (!rst_ni) stall_o |-> !instr_ret_o
  ) else begin
    errors++;
    $display("Assertion failed at %0t ns: instruction retired while stalled", $time);
  end

  // Open LSU request keeps the stage stalled
  a_lsu_req_stalls: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (lsu_req_o.req && !lsu_valid_i) |-> stall_o
  ) else begin
    errors++;
    $display("Assertion failed at %0t ns: LSU request pending without stall", $time);
  end

  a_taken_branch_redirect: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (instr_new_i && instr_valid_i && branch_decision_i && instr_rdata_i[6:0] == 7'b1100011)
      |=> pc_set_o
  ) else begin
    errors++;
    $display("Assertion failed at %0t ns: no PC set one cycle after a taken branch", $time);
  end

  a_not_taken_branch: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (instr_new_i && instr_valid_i && !branch_decision_i && instr_rdata_i[6:0] == 7'b1100011)
      |-> instr_ret_o ##1 !pc_set_o
  ) else begin
    errors++;
    $display("Assertion failed at %0t ns: not-taken branch did not retire cleanly", $time);
  end

  a_pc_set_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pc_set_o |=> !pc_set_o
  ) else begin
    errors++;
    $display("Assertion failed at %0t ns: pc_set_o held longer than one cycle", $time);
  end

endmodule

// ==== build.f ====
id_pkg.sv
id_decoder.sv
id_operand_mux.sv
id_register_file.sv
id_wb_ctrl.sv
id_stage.sv
tb_id_stage.sv
